//--- logic/rv_wb_pkg.sv
/*
 * Shared definitions for the write-back end of the RV32 integer pipeline.
 * Widths, opcode and func3 codes, exception cause indices, stage structs
 * and the data-memory FSM states. Modules refer to them by scoped name.
 */
package rv_wb_pkg;

  ////////////////////
  // Widths and base types
  ////////////////////
  localparam int XLEN     = 32;
  localparam int EXC_SIZE = 16;

  typedef logic [XLEN-1:0]     xlen_t;
  typedef logic [31:0]         instr_t;
  typedef logic [4:0]          reg_idx_t;
  typedef logic [EXC_SIZE-1:0] exc_t;

  // Exception cause bit positions in exc_t
  localparam int CAUSE_MISALIGNED_LOAD     = 4;
  localparam int CAUSE_LOAD_ACCESS_FAULT   = 5;
  localparam int CAUSE_MISALIGNED_STORE    = 6;
  localparam int CAUSE_STORE_ACCESS_FAULT  = 7;
  localparam int CAUSE_LOAD_PAGE_FAULT     = 13;
  localparam int CAUSE_STORE_PAGE_FAULT    = 15;

  // Major opcodes, instr[6:2]
  localparam logic [4:0] OPC_LOAD     = 5'b00000;
  localparam logic [4:0] OPC_MISC_MEM = 5'b00011;
  localparam logic [4:0] OPC_STORE    = 5'b01000;
  localparam logic [4:0] OPC_STORE_FP = 5'b01001;
  localparam logic [4:0] OPC_BRANCH   = 5'b11000;

  // Load widths, instr[14:12]
  localparam logic [2:0] F3_LB  = 3'b000;
  localparam logic [2:0] F3_LH  = 3'b001;
  localparam logic [2:0] F3_LW  = 3'b010;
  localparam logic [2:0] F3_LBU = 3'b100;
  localparam logic [2:0] F3_LHU = 3'b101;

  // addi x0, x0, 0
  localparam instr_t INSTR_NOP = 32'h0000_0013;
  localparam xlen_t  PC_INIT   = 32'h8000_0000;

  // Request cycles before a silent memory counts as an access fault
  localparam int TIMEOUT_CYCLES = 8;
  typedef logic [3:0] timer_cnt_t;

  ////////////////////
  // Stage structs
  ////////////////////
  typedef struct packed {
    xlen_t  pc;
    instr_t instr;
    logic   bubble;
    exc_t   exception;
    xlen_t  r;        // ALU result
    xlen_t  memadr;
  } mem_op_t;

  typedef struct packed {
    logic  ack;
    logic  err;
    logic  page_fault;
    xlen_t q;
  } dmem_rsp_t;

  typedef struct packed {
    xlen_t    pc;
    instr_t   instr;
    logic     bubble;
    exc_t     exception;
    xlen_t    badaddr;
    reg_idx_t dst;
    xlen_t    r;
    logic     we;
  } wb_out_t;

  typedef enum logic {
    DMEM_IDLE,
    DMEM_WAIT
  } dmem_state_e;

endpackage

//--- logic/rv_dmem_fsm.sv
/*
 * Data-memory access sequencer. One access per load or store.
 * Leaves idle when the stage flags an access, holds the request in
 * the wait state and drops it on ack, err or timeout.
 */
`timescale 1ns/1ps

module rv_dmem_fsm (
  input  logic clk_i,
  input  logic rst_ni,
  // Held operation needs a memory access
  input  logic access_i,
  // Ack, err or timeout this cycle
  input  logic resp_i,
  output logic req_o,
  output logic busy_o
);

  rv_wb_pkg::dmem_state_e state_q;
  rv_wb_pkg::dmem_state_e state_d;

  ////////////////////
  // Next state
  ////////////////////
  always_comb begin
    state_d = state_q;
    case (state_q)
      rv_wb_pkg::DMEM_IDLE: begin
        // Request goes out the cycle after the op shows up
        if (access_i) begin
          state_d = rv_wb_pkg::DMEM_WAIT;
        end
      end
      rv_wb_pkg::DMEM_WAIT: begin
        // Stage captures on this same edge
        if (resp_i) begin
          state_d = rv_wb_pkg::DMEM_IDLE;
        end
      end
      default: begin
        state_d = rv_wb_pkg::DMEM_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= rv_wb_pkg::DMEM_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Request level for the memory
  assign req_o  = (state_q == rv_wb_pkg::DMEM_WAIT);
  // Qualifies ack and err in the stage
  assign busy_o = (state_q == rv_wb_pkg::DMEM_WAIT);

endmodule

//--- logic/rv_dmem_timer.sv
/*
 * Wait-cycle counter for the data-memory request.
 * Flags the last allowed request cycle of an unanswered access.
 */
`timescale 1ns/1ps

module rv_dmem_timer (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic req_i,
  output logic timeout_o
);

  rv_wb_pkg::timer_cnt_t cnt_q;

  // Counts request cycles already spent, cleared once req drops
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else if (!req_i) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_q + rv_wb_pkg::timer_cnt_t'(1);
    end
  end

  // Current cycle is request cycle number TIMEOUT_CYCLES
  assign timeout_o = req_i &&
    (cnt_q == rv_wb_pkg::timer_cnt_t'(rv_wb_pkg::TIMEOUT_CYCLES - 1));

endmodule

//--- logic/rv_load_align.sv
/*
 * Load data extraction for RV32.
 * Moves the addressed byte or half-word down to bit 0 and extends it
 * by func3. Purely combinational.
 */
`timescale 1ns/1ps

module rv_load_align (
  input  rv_wb_pkg::instr_t instr_i,
  input  rv_wb_pkg::xlen_t  adr_i,
  input  rv_wb_pkg::xlen_t  q_i,
  output rv_wb_pkg::xlen_t  load_data_o
);

  logic [2:0]       func3;
  rv_wb_pkg::xlen_t q_sh;

  assign func3 = instr_i[14:12];

  // Byte lane select, shift by 8 * adr[1:0]
  assign q_sh = q_i >> {adr_i[1:0], 3'b000};

  always_comb begin
    case (func3)
      rv_wb_pkg::F3_LB: begin
        load_data_o = {{(rv_wb_pkg::XLEN - 8){q_sh[7]}}, q_sh[7:0]};
      end
      rv_wb_pkg::F3_LH: begin
        load_data_o = {{(rv_wb_pkg::XLEN - 16){q_sh[15]}}, q_sh[15:0]};
      end
      rv_wb_pkg::F3_LBU: begin
        load_data_o = {{(rv_wb_pkg::XLEN - 8){1'b0}}, q_sh[7:0]};
      end
      rv_wb_pkg::F3_LHU: begin
        load_data_o = {{(rv_wb_pkg::XLEN - 16){1'b0}}, q_sh[15:0]};
      end
      // Aligned word, no lane move
      rv_wb_pkg::F3_LW: begin
        load_data_o = q_i;
      end
      default: begin
        load_data_o = q_sh;
      end
    endcase
  end

endmodule

//--- logic/rv_wb_stage.sv
/*
 * Write-back register stage. Decodes the memory op, detects misalignment,
 * merges memory faults into the exception vector and drives the
 * register-file write port. Stalls while a data access is outstanding.
 */
`timescale 1ns/1ps

module rv_wb_stage (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  rv_wb_pkg::mem_op_t   mem_op_i,
  input  rv_wb_pkg::dmem_rsp_t rsp_i,
  input  logic                 timeout_i,
  input  logic                 busy_i,
  input  rv_wb_pkg::xlen_t     load_data_i,
  output logic                 access_o,
  output logic                 stall_o,
  output rv_wb_pkg::wb_out_t   wb_o
);

  logic [4:0]          opcode;
  logic [2:0]          func3;
  rv_wb_pkg::reg_idx_t dst;
  logic                is_load;
  logic                is_store;
  logic                mem_ok;
  logic                misaligned;
  logic                answered;
  logic                acc_fault;
  logic                pg_fault;
  logic                mem_cause;
  logic                writes;
  logic                we_d;
  rv_wb_pkg::exc_t     exc_d;

  // Stage registers
  rv_wb_pkg::xlen_t    pc_q;
  rv_wb_pkg::instr_t   instr_q;
  logic                bubble_q;
  rv_wb_pkg::exc_t     exc_q;
  logic                we_q;
  rv_wb_pkg::xlen_t    badaddr_q;
  rv_wb_pkg::reg_idx_t dst_q;
  rv_wb_pkg::xlen_t    r_q;

  ////////////////////
  // Decode
  ////////////////////
  assign opcode   = mem_op_i.instr[6:2];
  assign func3    = mem_op_i.instr[14:12];
  assign dst      = mem_op_i.instr[11:7];
  assign is_load  = (opcode == rv_wb_pkg::OPC_LOAD);
  assign is_store = (opcode == rv_wb_pkg::OPC_STORE);

  // Live memory op, no earlier trap pending
  assign mem_ok = (is_load | is_store) & ~mem_op_i.bubble & ~(|mem_op_i.exception);

  // func3[1:0] gives the size for loads and stores alike
  assign misaligned =
    ((func3[1:0] == rv_wb_pkg::F3_LH[1:0]) & mem_op_i.memadr[0]) |
    ((func3[1:0] == rv_wb_pkg::F3_LW[1:0]) & (|mem_op_i.memadr[1:0]));

  // Misaligned ops never reach the memory
  assign access_o = mem_ok & ~misaligned;

  ////////////////////
  // Memory response
  ////////////////////
  assign answered  = busy_i & (rsp_i.ack | rsp_i.err);
  // An ack in the last wait cycle beats the timeout
  assign acc_fault = busy_i & (rsp_i.err | (timeout_i & ~rsp_i.ack));
  assign pg_fault  = answered & rsp_i.page_fault;

  assign stall_o = access_o & ~(answered | (busy_i & timeout_i));

  // Merge memory causes, split load / store
  always_comb begin
    exc_d = mem_op_i.exception;
    if (mem_ok) begin
      exc_d[rv_wb_pkg::CAUSE_MISALIGNED_LOAD]    = is_load & misaligned;
      exc_d[rv_wb_pkg::CAUSE_MISALIGNED_STORE]   = is_store & misaligned;
      exc_d[rv_wb_pkg::CAUSE_LOAD_ACCESS_FAULT]  = is_load & acc_fault;
      exc_d[rv_wb_pkg::CAUSE_STORE_ACCESS_FAULT] = is_store & acc_fault;
      exc_d[rv_wb_pkg::CAUSE_LOAD_PAGE_FAULT]    = is_load & pg_fault;
      exc_d[rv_wb_pkg::CAUSE_STORE_PAGE_FAULT]   = is_store & pg_fault;
    end
  end

  assign mem_cause = exc_d[rv_wb_pkg::CAUSE_MISALIGNED_LOAD] |
                     exc_d[rv_wb_pkg::CAUSE_MISALIGNED_STORE] |
                     exc_d[rv_wb_pkg::CAUSE_LOAD_ACCESS_FAULT] |
                     exc_d[rv_wb_pkg::CAUSE_STORE_ACCESS_FAULT] |
                     exc_d[rv_wb_pkg::CAUSE_LOAD_PAGE_FAULT] |
                     exc_d[rv_wb_pkg::CAUSE_STORE_PAGE_FAULT];

  ////////////////////
  // Register-file write
  ////////////////////
  always_comb begin
    case (opcode)
      rv_wb_pkg::OPC_STORE,
      rv_wb_pkg::OPC_STORE_FP,
      rv_wb_pkg::OPC_BRANCH,
      rv_wb_pkg::OPC_MISC_MEM: writes = 1'b0;
      default:                 writes = 1'b1;
    endcase
  end

  assign we_d = writes & ~mem_op_i.bubble & ~(|exc_d) & (|dst);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pc_q     <= rv_wb_pkg::PC_INIT;
      instr_q  <= rv_wb_pkg::INSTR_NOP;
      bubble_q <= 1'b1;
      exc_q    <= '0;
      we_q     <= 1'b0;
    end else begin
      if (!stall_o) begin
        pc_q     <= mem_op_i.pc;
        instr_q  <= mem_op_i.instr;
        bubble_q <= mem_op_i.bubble;
        exc_q    <= exc_d;
      end
      // No repeated write while the next op waits on memory
      we_q <= we_d & ~stall_o;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!stall_o) begin
      dst_q     <= dst;
      r_q       <= is_load ? load_data_i : mem_op_i.r;
      badaddr_q <= mem_cause ? mem_op_i.memadr : mem_op_i.pc;
    end
  end

  always_comb begin
    wb_o.pc        = pc_q;
    wb_o.instr     = instr_q;
    wb_o.bubble    = bubble_q;
    wb_o.exception = exc_q;
    wb_o.badaddr   = badaddr_q;
    wb_o.dst       = dst_q;
    wb_o.r         = r_q;
    wb_o.we        = we_q;
  end

endmodule

//--- logic/rv_wb_top.sv
/*
 * Top of the memory-response and write-back end. Connects the access
 * FSM, the wait timer, the load aligner and the write-back stage to the
 * data memory and the register-file write port.
 */
`timescale 1ns/1ps

module rv_wb_top (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  // From the memory stage, held while stall_o is high
  input  rv_wb_pkg::mem_op_t   mem_op_i,
  // Data memory
  input  rv_wb_pkg::dmem_rsp_t dmem_rsp_i,
  output logic                 dmem_req_o,
  output rv_wb_pkg::xlen_t     dmem_adr_o,
  output logic                 stall_o,
  // Register-file write port and trap info
  output rv_wb_pkg::wb_out_t   wb_o
);

  logic             access;
  logic             busy;
  logic             timeout;
  rv_wb_pkg::xlen_t load_data;

  assign dmem_adr_o = mem_op_i.memadr;

  rv_dmem_fsm i_fsm (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .access_i (access),
    .resp_i   (dmem_rsp_i.ack | dmem_rsp_i.err | timeout),
    .req_o    (dmem_req_o),
    .busy_o   (busy)
  );

  rv_dmem_timer i_timer (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .req_i     (dmem_req_o),
    .timeout_o (timeout)
  );

  rv_load_align i_align (
    .instr_i     (mem_op_i.instr),
    .adr_i       (mem_op_i.memadr),
    .q_i         (dmem_rsp_i.q),
    .load_data_o (load_data)
  );

  rv_wb_stage i_stage (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .mem_op_i    (mem_op_i),
    .rsp_i       (dmem_rsp_i),
    .timeout_i   (timeout),
    .busy_i      (busy),
    .load_data_i (load_data),
    .access_o    (access),
    .stall_o     (stall_o),
    .wb_o        (wb_o)
  );

endmodule

//--- verification/rv_wb_tb_clk.sv
/*
 * Clock and reset source for the write-back testbench.
 * 100 ns clock, active-low reset released after 3 rising edges.
 */
`timescale 1ns/1ps

module rv_wb_tb_clk (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #50 clk_o = ~clk_o;
  end

  // Release lands on an edge, so no flop sees a partial cycle
  initial begin
    rst_no = 1'b0;
    repeat (3) @(posedge clk_o);
    rst_no <= 1'b1;
  end

endmodule

//--- verification/rv_wb_sva.sv
/*
 * Protocol assertions for the data-memory side of rv_wb_top.
 * Bound into the top level from the testbench. Reads the timeout net
 * of the top level as well as its ports.
 */
`timescale 1ns/1ps

module rv_wb_sva (
  input logic                 clk_i,
  input logic                 rst_ni,
  input logic                 req_i,
  input rv_wb_pkg::dmem_rsp_t rsp_i,
  input logic                 stall_i,
  input logic                 timeout_i
);

  logic done;

  // Any of the three ways an access can end
  assign done = rsp_i.ack | rsp_i.err | timeout_i;

  // Request stays up until the access ends
  req_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_i && !done |=> req_i)
    else $error("dmem_req_o dropped before ack, err or timeout");

  // And drops right after it
  req_released: assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_i && done |=> !req_i)
    else $error("dmem_req_o still high after the access ended");

  // A stall in idle belongs to an access whose request goes out next
  stall_starts_request: assert property (@(posedge clk_i) disable iff (!rst_ni)
    stall_i && !req_i |=> req_i)
    else $error("stall_o high in idle with no request following");

  rsp_in_request: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rsp_i.ack || rsp_i.err |-> req_i)
    else $error("ack or err seen outside a request");

endmodule

//--- verification/rv_wb_tb.sv
/*
 * Testbench for rv_wb_top. Random ALU, load, store, branch and fence ops
 * run against a cycle model of the access sequence and the write-back
 * rules. A built-in memory answers after a random number of request
 * cycles, or not at all so that the timeout fires.
 */
`timescale 1ns/1ps

module rv_wb_tb;

  logic                 clk;
  logic                 rst_n;
  rv_wb_pkg::mem_op_t   mem_op;
  rv_wb_pkg::dmem_rsp_t dmem_rsp;
  logic                 dmem_req;
  rv_wb_pkg::xlen_t     dmem_adr;
  logic                 stall;
  rv_wb_pkg::wb_out_t   wb;

  integer seed = 32'h3ed3_7f77;
  int     num_ops = 400;
  int     done_ops;

  // Model state for the cycle now applied to the DUT
  rv_wb_pkg::mem_op_t   op_m;
  rv_wb_pkg::dmem_rsp_t rsp_m;
  rv_wb_pkg::wb_out_t   exp_wb;
  logic                 in_wait;
  int                   req_cnt;
  int                   rsp_wait;
  int                   rsp_kind;
  logic                 check_due;

  rv_wb_tb_clk i_clk (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  rv_wb_top i_rv_wb_top (
    .clk_i      (clk),
    .rst_ni     (rst_n),
    .mem_op_i   (mem_op),
    .dmem_rsp_i (dmem_rsp),
    .dmem_req_o (dmem_req),
    .dmem_adr_o (dmem_adr),
    .stall_o    (stall),
    .wb_o       (wb)
  );

  bind rv_wb_top rv_wb_sva i_rv_wb_sva (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .req_i     (dmem_req_o),
    .rsp_i     (dmem_rsp_i),
    .stall_i   (stall_o),
    .timeout_i (timeout)
  );

  ////////////////////
  // Failure and compare
  ////////////////////
  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("TESTS FAILED");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_word(input rv_wb_pkg::xlen_t act, input rv_wb_pkg::xlen_t exp,
                            input string what);
    if (act !== exp) begin
      stop_run($sformatf("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, act, exp));
    end
  endtask

  task automatic check_exc(input rv_wb_pkg::exc_t act, input rv_wb_pkg::exc_t exp,
                           input string what);
    if (act !== exp) begin
      stop_run($sformatf("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, act, exp));
    end
  endtask

  task automatic check_idx(input rv_wb_pkg::reg_idx_t act, input rv_wb_pkg::reg_idx_t exp,
                           input string what);
    if (act !== exp) begin
      stop_run($sformatf("CHECK FAILED at %0t: %s is %0d, expected %0d", $time, what, act, exp));
    end
  endtask

  task automatic check_flag(input logic act, input logic exp, input string what);
    if (act !== exp) begin
      stop_run($sformatf("CHECK FAILED at %0t: %s is %b, expected %b", $time, what, act, exp));
    end
  endtask

  ////////////////////
  // Random stimulus
  ////////////////////
  function automatic int pick(input int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  function automatic rv_wb_pkg::xlen_t rand_word();
    return $random(seed);
  endfunction

  function automatic rv_wb_pkg::mem_op_t random_op();
    rv_wb_pkg::mem_op_t op;
    rv_wb_pkg::xlen_t   bits;
    logic [4:0]         opc;
    logic [2:0]         f3;
    bits = rand_word();
    f3 = bits[14:12];
    case (pick(8))
      0, 1: opc = (pick(2) == 0) ? 5'b01100 : 5'b00100;
      2, 3: begin
        opc = rv_wb_pkg::OPC_LOAD;
        case (pick(5))
          0: f3 = rv_wb_pkg::F3_LB;
          1: f3 = rv_wb_pkg::F3_LH;
          2: f3 = rv_wb_pkg::F3_LW;
          3: f3 = rv_wb_pkg::F3_LBU;
          default: f3 = rv_wb_pkg::F3_LHU;
        endcase
      end
      // SB, SH or SW
      4: begin
        opc = rv_wb_pkg::OPC_STORE;
        f3 = 3'(pick(3));
      end
      5: opc = rv_wb_pkg::OPC_BRANCH;
      6: begin
        opc = rv_wb_pkg::OPC_MISC_MEM;
        f3 = 3'b000;
      end
      default: begin
        opc = rv_wb_pkg::OPC_STORE_FP;
        f3 = 3'b010;
      end
    endcase
    op.instr = {bits[31:15], f3, bits[11:7], opc, 2'b11};
    if (pick(8) == 0) begin
      op.instr[11:7] = '0;
    end
    op.pc = rand_word() & 32'hffff_fffc;
    op.r = rand_word();
    op.memadr = rand_word();
    // Half of the addresses aligned to a word
    if (pick(2) == 0) begin
      op.memadr[1:0] = 2'b00;
    end
    op.bubble = (pick(8) == 0);
    op.exception = (pick(8) == 0) ? rv_wb_pkg::exc_t'(1) << pick(16) : '0;
    return op;
  endfunction

  ////////////////////
  // Reference model
  ////////////////////
  function automatic logic is_mem_op(input rv_wb_pkg::mem_op_t op);
    logic [4:0] opc;
    opc = op.instr[6:2];
    return (opc == rv_wb_pkg::OPC_LOAD || opc == rv_wb_pkg::OPC_STORE) &&
           !op.bubble && op.exception == '0;
  endfunction

  // Access size from func3[1:0] for loads and stores alike
  function automatic logic misaligned(input rv_wb_pkg::mem_op_t op);
    logic [1:0] size;
    size = op.instr[13:12];
    return (size == 2'd1 && op.memadr[0]) || (size == 2'd2 && op.memadr[1:0] != 2'd0);
  endfunction

  function automatic logic needs_access(input rv_wb_pkg::mem_op_t op);
    return is_mem_op(op) && !misaligned(op);
  endfunction

  function automatic rv_wb_pkg::xlen_t load_value(input rv_wb_pkg::instr_t instr,
                                                  input rv_wb_pkg::xlen_t adr,
                                                  input rv_wb_pkg::xlen_t q);
    rv_wb_pkg::xlen_t lane;
    lane = q >> (8 * int'(adr[1:0]));
    case (instr[14:12])
      rv_wb_pkg::F3_LB:  return {{24{lane[7]}}, lane[7:0]};
      rv_wb_pkg::F3_LH:  return {{16{lane[15]}}, lane[15:0]};
      rv_wb_pkg::F3_LBU: return {24'h0, lane[7:0]};
      rv_wb_pkg::F3_LHU: return {16'h0, lane[15:0]};
      // Word loads take q as it is
      default:           return q;
    endcase
  endfunction

  function automatic rv_wb_pkg::wb_out_t expect_wb(input rv_wb_pkg::mem_op_t op,
                                                   input rv_wb_pkg::dmem_rsp_t rsp,
                                                   input logic waiting, input int cnt);
    rv_wb_pkg::wb_out_t w;
    rv_wb_pkg::exc_t    mask;
    logic [4:0]         opc;
    logic               ld;
    logic               fault;
    logic               pf;
    opc = op.instr[6:2];
    ld = (opc == rv_wb_pkg::OPC_LOAD);
    // Ack in the last allowed cycle still counts as an answer
    fault = waiting && (rsp.err || (cnt == rv_wb_pkg::TIMEOUT_CYCLES && !rsp.ack));
    pf = waiting && (rsp.ack || rsp.err) && rsp.page_fault;
    w.exception = op.exception;
    if (is_mem_op(op)) begin
      if (misaligned(op)) begin
        w.exception[ld ? rv_wb_pkg::CAUSE_MISALIGNED_LOAD
                       : rv_wb_pkg::CAUSE_MISALIGNED_STORE] = 1'b1;
      end
      if (fault) begin
        w.exception[ld ? rv_wb_pkg::CAUSE_LOAD_ACCESS_FAULT
                       : rv_wb_pkg::CAUSE_STORE_ACCESS_FAULT] = 1'b1;
      end
      if (pf) begin
        w.exception[ld ? rv_wb_pkg::CAUSE_LOAD_PAGE_FAULT
                       : rv_wb_pkg::CAUSE_STORE_PAGE_FAULT] = 1'b1;
      end
    end
    mask = '0;
    mask[rv_wb_pkg::CAUSE_MISALIGNED_LOAD] = 1'b1;
    mask[rv_wb_pkg::CAUSE_LOAD_ACCESS_FAULT] = 1'b1;
    mask[rv_wb_pkg::CAUSE_MISALIGNED_STORE] = 1'b1;
    mask[rv_wb_pkg::CAUSE_STORE_ACCESS_FAULT] = 1'b1;
    mask[rv_wb_pkg::CAUSE_LOAD_PAGE_FAULT] = 1'b1;
    mask[rv_wb_pkg::CAUSE_STORE_PAGE_FAULT] = 1'b1;
    w.pc = op.pc;
    w.instr = op.instr;
    w.bubble = op.bubble;
    w.dst = op.instr[11:7];
    w.r = ld ? load_value(op.instr, op.memadr, rsp.q) : op.r;
    w.badaddr = ((w.exception & mask) != '0) ? op.memadr : op.pc;
    w.we = !(opc inside {rv_wb_pkg::OPC_STORE, rv_wb_pkg::OPC_STORE_FP,
                         rv_wb_pkg::OPC_BRANCH, rv_wb_pkg::OPC_MISC_MEM}) &&
           !op.bubble && w.exception == '0 && w.dst != '0;
    return w;
  endfunction

  ////////////////////
  // Per-cycle driver
  ////////////////////
  // Runs at the rising edge on the values of the cycle just ending
  task automatic step_cycle();
    logic acc;
    logic resp;
    logic exp_stall;
    acc = needs_access(op_m);
    resp = in_wait && (rsp_m.ack || rsp_m.err || req_cnt == rv_wb_pkg::TIMEOUT_CYCLES);
    exp_stall = acc && !resp;
    check_flag(dmem_req, in_wait, "dmem_req_o");
    check_flag(stall, exp_stall, "stall_o");
    check_word(dmem_adr, op_m.memadr, "dmem_adr_o");
    check_due = !exp_stall;
    if (!exp_stall) begin
      exp_wb = expect_wb(op_m, rsp_m, in_wait, req_cnt);
    end
    // Access FSM with request cycles counted from 1
    if (in_wait && resp) begin
      in_wait = 1'b0;
      req_cnt = 0;
    end else if (in_wait) begin
      req_cnt++;
    end else if (acc) begin
      in_wait = 1'b1;
      req_cnt = 1;
    end
    // Memory answers after rsp_wait silent request cycles
    rsp_m.ack = 1'b0;
    rsp_m.err = 1'b0;
    rsp_m.page_fault = 1'b0;
    if (in_wait && req_cnt == rsp_wait + 1) begin
      rsp_m.q = rand_word();
      case (rsp_kind)
        0: rsp_m.ack = 1'b1;
        1: rsp_m.err = 1'b1;
        default: begin
          rsp_m.ack = 1'b1;
          rsp_m.page_fault = 1'b1;
        end
      endcase
    end
    if (!in_wait) begin
      rsp_wait = pick(11);
      rsp_kind = pick(3);
    end
    if (!exp_stall) begin
      done_ops++;
      op_m = random_op();
    end
    mem_op <= op_m;
    dmem_rsp <= rsp_m;
  endtask

  task automatic compare_wb();
    check_word(wb.pc, exp_wb.pc, "wb pc");
    check_word(wb.instr, exp_wb.instr, "wb instr");
    check_flag(wb.bubble, exp_wb.bubble, "wb bubble");
    check_exc(wb.exception, exp_wb.exception, "wb exception");
    check_word(wb.badaddr, exp_wb.badaddr, "wb badaddr");
    check_idx(wb.dst, exp_wb.dst, "wb dst");
    check_word(wb.r, exp_wb.r, "wb r");
    check_flag(wb.we, exp_wb.we, "wb we");
  endtask

  initial begin
    done_ops = 0;
    in_wait = 1'b0;
    req_cnt = 0;
    check_due = 1'b0;
    op_m = '0;
    op_m.pc = rv_wb_pkg::PC_INIT;
    op_m.instr = rv_wb_pkg::INSTR_NOP;
    op_m.bubble = 1'b1;
    rsp_m = '0;
    rsp_wait = pick(11);
    rsp_kind = pick(3);
    mem_op <= op_m;
    dmem_rsp <= rsp_m;
    wait (rst_n === 1'b1);
    @(negedge clk);
    // State left by reset
    check_flag(wb.bubble, 1'b1, "wb bubble after reset");
    check_word(wb.pc, rv_wb_pkg::PC_INIT, "wb pc after reset");
    check_word(wb.instr, rv_wb_pkg::INSTR_NOP, "wb instr after reset");
    check_flag(wb.we, 1'b0, "wb we after reset");
    check_flag(dmem_req, 1'b0, "dmem_req_o after reset");
    check_flag(stall, 1'b0, "stall_o after reset");
    while (done_ops < num_ops) begin
      @(posedge clk);
      step_cycle();
      @(negedge clk);
      if (check_due) begin
        compare_wb();
      end
    end
    $display("TESTS PASSED");
    $finish;
  end

  // Worst case is one idle and TIMEOUT_CYCLES request cycles per op
  initial begin
    #(num_ops * 12 * 100);
    stop_run("Watchdog expired before all operations completed");
  end

endmodule

//--- rv_wb.f
logic/rv_wb_pkg.sv
logic/rv_dmem_fsm.sv
logic/rv_dmem_timer.sv
logic/rv_load_align.sv
logic/rv_wb_stage.sv
logic/rv_wb_top.sv
verification/rv_wb_tb_clk.sv
verification/rv_wb_sva.sv
verification/rv_wb_tb.sv

//--- run_sim.sh
#!/bin/sh
# Compile the testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module rv_wb_tb -f rv_wb.f -o rv_wb_sim || { echo "Build failed"; exit 1; }
out="$(./obj_dir/rv_wb_sim 2>&1)"
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "TESTS PASSED" && echo "Simulation passed" ||
  { echo "Simulation failed"; exit 1; }
